//--- rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// ------------------------------
	// Widths and memory geometry
	// ------------------------------
	localparam int RAM_WORDS = 256;
	localparam int RAM_LATENCY = 2;	// Strobe to ready pulse, in cycles
	localparam int CACHE_LINES = 8;
	localparam int CACHE_IDX_W = $clog2(CACHE_LINES);
	localparam int CACHE_TAG_W = 30 - CACHE_IDX_W;	// Word address bits above the index
	localparam int NUM_REGS = 16;

	typedef logic [31:0] word_t;
	typedef logic [3:0] reg_idx_t;
	typedef logic [$clog2(RAM_WORDS)-1:0] ram_addr_t;
	typedef logic [3:0] opc_t;

	// ------------------------------
	// Instruction fields
	// ------------------------------
	localparam int CLS_LO = 25;
	localparam int IMM_BIT = 25;	// Low class bit doubles as the immediate flag
	localparam int OPC_LO = 21;
	localparam int RN_LO = 16;
	localparam int RD_LO = 12;
	localparam int RM_LO = 0;
	localparam int IMM8_LO = 0;
	localparam int OFF_LO = 0;
	localparam int OFF_W = 24;
	localparam logic [1:0] CLS_DP = 2'b00;	// Upper two class bits
	localparam logic [2:0] CLS_B = 3'b101;

	localparam opc_t OPC_AND = 4'd0;
	localparam opc_t OPC_EOR = 4'd1;
	localparam opc_t OPC_SUB = 4'd2;
	localparam opc_t OPC_ADD = 4'd4;
	localparam opc_t OPC_ORR = 4'd12;
	localparam opc_t OPC_MOV = 4'd13;

	typedef struct packed {
		logic bubble;
		word_t insn;
		word_t pc;
	} stage_t;

	typedef struct packed {
		logic read;
		ram_addr_t addr;
	} bus_req_t;

	typedef struct packed {
		logic ready;
		word_t data;
	} bus_rsp_t;

	typedef struct packed {
		logic valid;
		reg_idx_t num;
		word_t data;
	} wb_t;

	typedef struct packed {
		logic we;
		ram_addr_t addr;
		word_t data;
	} load_t;

	typedef enum logic [1:0] {
		CS_IDLE,
		CS_READ,
		CS_FILL
	} cache_state_e;

	function automatic opc_t f_opc(word_t insn);
		return insn[OPC_LO +: 4];
	endfunction

	function automatic reg_idx_t f_rn(word_t insn);
		return insn[RN_LO +: 4];
	endfunction

	function automatic reg_idx_t f_rd(word_t insn);
		return insn[RD_LO +: 4];
	endfunction

	function automatic reg_idx_t f_rm(word_t insn);
		return insn[RM_LO +: 4];
	endfunction

	// Unknown opcodes fall out here and run as no-ops
	function automatic logic is_alu(word_t insn);
		return insn[CLS_LO+1 +: 2] == CLS_DP && (f_opc(insn) inside
			{OPC_AND, OPC_EOR, OPC_SUB, OPC_ADD, OPC_ORR, OPC_MOV});
	endfunction

	function automatic logic is_branch(word_t insn);
		return insn[CLS_LO +: 3] == CLS_B;
	endfunction

	function automatic logic uses_rn(word_t insn);
		return is_alu(insn) && f_opc(insn) != OPC_MOV;
	endfunction

	function automatic logic uses_rm(word_t insn);
		return is_alu(insn) && !insn[IMM_BIT];
	endfunction

endpackage

`default_nettype wire

//--- rtl/instr_cache.sv
`timescale 1ns/100ps
`default_nettype none

module instr_cache import cpu_pkg::*; (
	input logic clk,
	input logic rst_n,
	input word_t rd_addr,
	input logic rd_req,
	output logic rd_wait,
	output word_t rd_data,
	output bus_req_t bus_req,
	input bus_rsp_t bus_rsp
);

	logic [CACHE_LINES-1:0] line_valid;
	logic [CACHE_TAG_W-1:0] line_tag [CACHE_LINES];
	word_t line_data [CACHE_LINES];
	cache_state_e state;
	word_t fill_addr;

	logic [CACHE_IDX_W-1:0] rd_idx;
	logic [CACHE_IDX_W-1:0] fill_idx;
	logic [CACHE_TAG_W-1:0] rd_tag;
	logic hit;
	logic fill_done;

	assign rd_idx = rd_addr[2 +: CACHE_IDX_W];
	assign rd_tag = rd_addr[31 -: CACHE_TAG_W];
	assign fill_idx = fill_addr[2 +: CACHE_IDX_W];
	assign hit = line_valid[rd_idx] && line_tag[rd_idx] == rd_tag;
	assign fill_done = state == CS_FILL && bus_rsp.ready;

	assign rd_wait = rd_req && !hit;
	assign rd_data = line_data[rd_idx];
	assign bus_req.read = state == CS_READ;	// One cycle per refill
	assign bus_req.addr = fill_addr[2 +: $bits(ram_addr_t)];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= CS_IDLE;
			line_valid <= '0;
		end
		else
		begin
			case (state)
				CS_IDLE:
					if (rd_wait)
						state <= CS_READ;
				CS_READ:
					state <= CS_FILL;
				CS_FILL:
					if (bus_rsp.ready)
					begin
						line_valid[fill_idx] <= 1'b1;
						state <= CS_IDLE;
					end
				default:
					state <= CS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == CS_IDLE && rd_wait)
			fill_addr <= rd_addr;	// Keeps refilling this line even if fetch jumps away
		if (fill_done)
		begin
			line_tag[fill_idx] <= fill_addr[31 -: CACHE_TAG_W];
			line_data[fill_idx] <= bus_rsp.data;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		bus_req.read |=> !bus_req.read until_with bus_rsp.ready)
		else $error("instr_cache: read strobe while a read is outstanding");

endmodule

`default_nettype wire

//--- rtl/block_ram.sv
`timescale 1ns/100ps
`default_nettype none

module block_ram import cpu_pkg::*; (
	input logic clk,
	input bus_req_t bus_req,
	output bus_rsp_t bus_rsp,
	input load_t load
);

	word_t mem [RAM_WORDS];
	bus_rsp_t rsp_pipe [RAM_LATENCY];

	// Read happens in the first stage, the rest only delays the response
	always_ff @(posedge clk)
	begin
		if (load.we)
			mem[load.addr] <= load.data;
		rsp_pipe[0].ready <= bus_req.read;
		rsp_pipe[0].data <= mem[bus_req.addr];
		for (int i = 1; i < RAM_LATENCY; i++)
			rsp_pipe[i] <= rsp_pipe[i-1];
	end

	assign bus_rsp = rsp_pipe[RAM_LATENCY-1];

endmodule

`default_nettype wire

//--- rtl/fetch.sv
`timescale 1ns/100ps
`default_nettype none

module fetch import cpu_pkg::*; (
	input logic clk,
	input logic rst_n,
	output word_t rd_addr,
	output logic rd_req,
	input logic rd_wait,
	input word_t rd_data,
	input logic stall,
	input logic jmp,
	input word_t jmppc,
	output stage_t out
);

	word_t pc;

	assign rd_addr = pc;
	assign rd_req = !stall;	// No new lookups while the output is held

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			pc <= '0;
			out.bubble <= 1'b1;
		end
		else if (jmp)
		begin
			pc <= jmppc;	// Redirect wins over stall and cache wait
			out.bubble <= 1'b1;
		end
		else if (!stall)
		begin
			if (rd_wait)
				out.bubble <= 1'b1;
			else
			begin
				out <= '{bubble: 1'b0, insn: rd_data, pc: pc};
				pc <= pc + 32'd4;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/issue.sv
`timescale 1ns/100ps
`default_nettype none

module issue import cpu_pkg::*; (
	input logic clk,
	input logic rst_n,
	input stage_t in,
	input wb_t wb,
	input logic flush,
	output logic stall,
	output stage_t out
);

	logic [NUM_REGS-1:0] pending;
	logic [NUM_REGS-1:0] wb_clear;
	logic [NUM_REGS-1:0] busy;
	logic [NUM_REGS-1:0] rd_set;
	logic take_alu;

	// A register written back this cycle is readable through the register file
	assign wb_clear = wb.valid ? NUM_REGS'(1) << wb.num : '0;
	assign busy = pending & ~wb_clear;

	assign stall = !in.bubble && ((uses_rn(in.insn) && busy[f_rn(in.insn)])
		|| (uses_rm(in.insn) && busy[f_rm(in.insn)]));

	assign take_alu = !in.bubble && !stall && !flush && is_alu(in.insn);
	assign rd_set = take_alu ? NUM_REGS'(1) << f_rd(in.insn) : '0;

	always_ff @(posedge clk)
	begin
		if (!rst_n || flush)
			pending <= '0;	// Nothing younger than the branch has issued
		else
			pending <= (pending & ~wb_clear) | rd_set;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			out.bubble <= 1'b1;
		else if (flush || stall)
			out.bubble <= 1'b1;
		else
			out <= in;
	end

	// Fetch drops its wrong-path word too, so the slot after that stays empty
	assert property (@(posedge clk) disable iff (!rst_n)
		flush |=> out.bubble ##1 out.bubble)
		else $error("issue: instruction issued behind a taken branch");

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file import cpu_pkg::*; (
	input logic clk,
	input logic rst_n,
	input reg_idx_t rd_num_a,
	input reg_idx_t rd_num_b,
	output word_t rd_data_a,
	output word_t rd_data_b,
	input wb_t wb
);

	word_t regs [NUM_REGS];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (wb.valid)
			regs[wb.num] <= wb.data;
	end

	// Write-through so decode sees a result in its write-back cycle
	assign rd_data_a = (wb.valid && wb.num == rd_num_a) ? wb.data : regs[rd_num_a];
	assign rd_data_b = (wb.valid && wb.num == rd_num_b) ? wb.data : regs[rd_num_b];

endmodule

`default_nettype wire

//--- rtl/decode.sv
`timescale 1ns/100ps
`default_nettype none

module decode import cpu_pkg::*; (
	input logic clk,
	input logic rst_n,
	input stage_t in,
	input logic stall,
	output reg_idx_t rd_num_a,
	output reg_idx_t rd_num_b,
	input word_t rd_data_a,
	input word_t rd_data_b,
	output word_t op1,
	output word_t op2
);

	word_t op2_next;

	assign rd_num_a = f_rn(in.insn);
	assign rd_num_b = f_rm(in.insn);
	assign op2_next = in.insn[IMM_BIT] ? word_t'(in.insn[IMM8_LO +: 8]) : rd_data_b;

	// Holds with issue so the operands stay paired with the issued instruction
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			op1 <= '0;
			op2 <= '0;
		end
		else if (!stall)
		begin
			op1 <= rd_data_a;
			op2 <= op2_next;
		end
	end

endmodule

`default_nettype wire

//--- rtl/execute.sv
`timescale 1ns/100ps
`default_nettype none

module execute import cpu_pkg::*; (
	input logic clk,
	input logic rst_n,
	input stage_t in,
	input word_t op1,
	input word_t op2,
	output logic jmp,
	output word_t jmppc,
	output wb_t wb
);

	word_t alu_res;
	logic [OFF_W-1:0] off;

	// ------------------------------
	// ALU
	// ------------------------------
	always_comb
	begin
		case (f_opc(in.insn))
			OPC_AND: alu_res = op1 & op2;
			OPC_EOR: alu_res = op1 ^ op2;
			OPC_SUB: alu_res = op1 - op2;
			OPC_ADD: alu_res = op1 + op2;
			OPC_ORR: alu_res = op1 | op2;
			OPC_MOV: alu_res = op2;
			default: alu_res = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			wb.valid <= 1'b0;
		else
		begin
			wb.valid <= !in.bubble && is_alu(in.insn);
			wb.num <= f_rd(in.insn);
			wb.data <= alu_res;
		end
	end

	// ------------------------------
	// Branch
	// ------------------------------
	assign off = in.insn[OFF_LO +: OFF_W];
	assign jmp = !in.bubble && is_branch(in.insn);
	assign jmppc = in.pc + 32'd4 + {{(32-OFF_W-2){off[OFF_W-1]}}, off, 2'b00};

	// The flush must turn the next issue slot into a bubble
	assert property (@(posedge clk) disable iff (!rst_n) jmp |-> !in.bubble ##1 !jmp)
		else $error("execute: branch taken twice or from a bubble");

endmodule

`default_nettype wire

//--- rtl/cpu_system.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_system import cpu_pkg::*; (
	input logic clk,
	input logic rst_n,
	input load_t load,
	output wb_t retire
);

	word_t rd_addr;
	logic rd_req;
	logic rd_wait;
	word_t rd_data;
	bus_req_t bus_req;
	bus_rsp_t bus_rsp;

	stage_t fetch_out;
	stage_t issue_out;
	logic stall;
	logic jmp;
	word_t jmppc;

	reg_idx_t rd_num_a;
	reg_idx_t rd_num_b;
	word_t rd_data_a;
	word_t rd_data_b;
	word_t op1;
	word_t op2;
	wb_t wb;

	// ------------------------------
	// Instruction memory path
	// ------------------------------
	instr_cache u_icache (
		.clk(clk), .rst_n(rst_n),
		.rd_addr(rd_addr), .rd_req(rd_req), .rd_wait(rd_wait), .rd_data(rd_data),
		.bus_req(bus_req), .bus_rsp(bus_rsp));

	block_ram u_ram (.clk(clk), .bus_req(bus_req), .bus_rsp(bus_rsp), .load(load));

	// ------------------------------
	// Pipeline
	// ------------------------------
	fetch u_fetch (
		.clk(clk), .rst_n(rst_n),
		.rd_addr(rd_addr), .rd_req(rd_req), .rd_wait(rd_wait), .rd_data(rd_data),
		.stall(stall), .jmp(jmp), .jmppc(jmppc), .out(fetch_out));

	issue u_issue (
		.clk(clk), .rst_n(rst_n),
		.in(fetch_out), .wb(wb), .flush(jmp), .stall(stall), .out(issue_out));

	reg_file u_regs (
		.clk(clk), .rst_n(rst_n),
		.rd_num_a(rd_num_a), .rd_num_b(rd_num_b),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b), .wb(wb));

	decode u_decode (
		.clk(clk), .rst_n(rst_n), .in(fetch_out), .stall(stall),
		.rd_num_a(rd_num_a), .rd_num_b(rd_num_b),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b), .op1(op1), .op2(op2));

	execute u_execute (
		.clk(clk), .rst_n(rst_n), .in(issue_out), .op1(op1), .op2(op2),
		.jmp(jmp), .jmppc(jmppc), .wb(wb));

	assign retire = wb;

endmodule

`default_nettype wire

//--- tb/retire_checker.sv
`timescale 1ns/100ps
`default_nettype none

module retire_checker import cpu_pkg::*; (
	input logic clk,
	input logic rst_n,
	input wb_t retire,
	output int checked,
	output int errors,
	output logic done
);

	localparam int TRACE_WORDS = 128;

	word_t trace [TRACE_WORDS];
	word_t exp_key [$];
	word_t exp_data [$];
	int exp_total;
	int grp_errors;
	int grp_writes;
	string grp_names [5];

	initial
	begin
		int prog_len;
		$readmemh("tb/cpu_trace.hex", trace);
		prog_len = trace[0];
		exp_total = trace[prog_len+1];
		for (int i = 0; i < exp_total; i++)
		begin
			exp_key.push_back(trace[prog_len + 2 + 2*i]);
			exp_data.push_back(trace[prog_len + 3 + 2*i]);
		end
		grp_names[0] = "unnamed";
		grp_names[1] = "immediate ALU operations";
		grp_names[2] = "dependent register chain";
		grp_names[3] = "forward branch";
		grp_names[4] = "unrolled loop across cache lines";
		checked = 0;
		errors = 0;
		grp_errors = 0;
		grp_writes = 0;
		done = (exp_total == 0);
	end

	// Key word holds the group in bits 11:8 and the register in bits 3:0
	task automatic compare_write(input word_t key, input word_t data);
		reg_idx_t exp_num;
		int grp;
		exp_num = key[3:0];
		grp = key[11:8];
		if (retire.num !== exp_num)
		begin
			$display("[ERROR] %0t ns retire.num expected %0d got %0d", $time, exp_num,
				retire.num);
			errors++;
			grp_errors++;
		end
		if (retire.data !== data)
		begin
			$display("[ERROR] %0t ns retire.data (r%0d) expected %h got %h", $time, exp_num,
				data, retire.data);
			errors++;
			grp_errors++;
		end
		grp_writes++;
		checked++;
		// Group ends at the last entry or where the next entry changes group
		if (checked == exp_total || exp_key[checked][11:8] != key[11:8])
		begin
			$display("Test %0d (%s): %0d writes, %s", grp, grp_names[grp > 4 ? 0 : grp],
				grp_writes, grp_errors == 0 ? "ok" : "FAILED");
			grp_errors = 0;
			grp_writes = 0;
		end
		if (checked == exp_total)
			done = 1'b1;
	endtask

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			if (retire.valid === 1'b1)
			begin
				$display("Retire of r%0d seen while reset was held", retire.num);
				errors++;
			end
		end
		else if (retire.valid === 1'b1)
		begin
			if (checked >= exp_total)
			begin
				$display("Unexpected retire of r%0d after all expected writes, at %0t ns",
					retire.num, $time);
				errors++;
				checked++;
			end
			else
				compare_write(exp_key[checked], exp_data[checked]);
		end
	end

endmodule

`default_nettype wire

//--- tb/tb_cpu_system.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_system import cpu_pkg::*; ();

	localparam int TRACE_WORDS = 128;
	localparam int LOAD_WORDS = 64;	// Program plus no-op fill past its end
	localparam int RESET_CYCLES = 10;
	localparam int QUIET_CYCLES = 50;

	logic clk = 1'b0;
	logic rst_n;
	load_t load;
	wb_t retire;

	word_t trace [TRACE_WORDS];
	int prog_len;
	int exp_count;
	int limit = 1000;
	int cycles = 0;

	int checked;
	int errors;
	logic done;

	always #5 clk = ~clk;

	cpu_system DUT (
		.clk(clk),
		.rst_n(rst_n),
		.load(load),
		.retire(retire)
	);

	retire_checker u_checker (
		.clk(clk),
		.rst_n(rst_n),
		.retire(retire),
		.checked(checked),
		.errors(errors),
		.done(done)
	);

	// ------------------------------
	// Program loading
	// ------------------------------

	// Class 011 is neither data processing nor branch, so it runs as a no-op
	function automatic word_t fill_word(int addr);
		return 32'hE600_0000 | word_t'(addr);
	endfunction

	task automatic write_ram(input int addr, input word_t data);
		@(negedge clk);
		load.we = 1'b1;
		load.addr = ram_addr_t'(addr);
		load.data = data;
	endtask

	initial
	begin
		rst_n = 1'b0;
		load = '0;
		$readmemh("tb/cpu_trace.hex", trace);
		prog_len = trace[0];
		exp_count = trace[prog_len+1];
		limit = 40 * exp_count + 100;	// Cycles from reset release
		for (int i = 0; i < LOAD_WORDS; i++)
			write_ram(i, (i < prog_len) ? trace[i+1] : fill_word(i));
		@(negedge clk);
		load = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		$display("Loaded %0d program words, expecting %0d writes", prog_len, exp_count);

		wait (done);
		repeat (QUIET_CYCLES) @(negedge clk);	// Core spins on the final branch here

		$display("Summary: %0d of %0d writes checked, %0d errors", checked, exp_count,
			errors);
		if (checked != exp_count)
			$display("Retire count %0d does not match the expected %0d", checked, exp_count);
		if (errors == 0 && checked == exp_count)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// ------------------------------
	// Timeout
	// ------------------------------
	always @(posedge clk)
	begin
		if (rst_n)
		begin
			cycles++;
			if (cycles >= limit)
			begin
				$display("Timeout after %0d cycles with %0d of %0d writes seen",
					cycles, checked, exp_count);
				$display("Checks failed");
				$finish;
			end
		end
	end

endmodule

`default_nettype wire

//--- tb/cpu_trace.hex
// Program: word count, then the instruction words from address 0
// Expected: write count, then pairs of key {group[11:8], reg[3:0]} and data
00000023
E3A01055 E2812010 E2423005 E201400F E38150A0 E22160FF
E0817002 E0478003 E0289007 E1A0A009 E044B005 E18BC00A E00CD006
EA000002 E3A000EE E3A000DD E28DE001
E3A0F000 E28FF003 EA000004 E3A000A0 E3A000A1 E3A000A2 E3A000A3
E28FF003 EA000006 E3A000B0 E3A000B1 E3A000B2 E3A000B3 E3A000B4 E3A000B5
E28FF003 E08F100E EAFFFFFF
00000013
00000101 00000055
00000102 00000065
00000103 00000060
00000104 00000005
00000105 000000F5
00000106 000000AA
00000207 000000BA
00000208 0000005A
00000209 000000E0
0000020A 000000E0
0000020B FFFFFF10
0000020C FFFFFFF0
0000020D 000000A0
0000030E 000000A1
0000040F 00000000
0000040F 00000003
0000040F 00000006
0000040F 00000009
00000401 000000AA

//--- filelist.f
rtl/cpu_pkg.sv
rtl/instr_cache.sv
rtl/block_ram.sv
rtl/fetch.sv
rtl/issue.sv
rtl/reg_file.sv
rtl/decode.sv
rtl/execute.sv
rtl/cpu_system.sv
tb/retire_checker.sv
tb/tb_cpu_system.sv

//--- Bender.yml
package:
  name: cpu_system

sources:
  - rtl/cpu_pkg.sv
  - rtl/instr_cache.sv
  - rtl/block_ram.sv
  - rtl/fetch.sv
  - rtl/issue.sv
  - rtl/reg_file.sv
  - rtl/decode.sv
  - rtl/execute.sv
  - rtl/cpu_system.sv
  - target: test
    files:
      - tb/retire_checker.sv
      - tb/tb_cpu_system.sv
